// File: rtl/lcd_pkg.sv
// panel command encoding, opcode enum, command-word types, command table and table offsets
`default_nettype none

package lcd_pkg;

    typedef enum logic [1:0] {
        op_reg_addr  = 2'd0,    // register address, sent with dc low
        op_dat_byte  = 2'd1,    // register data, sent with dc high
        op_delay     = 2'd2,    // wait argument milliseconds
        op_reset_pin = 2'd3     // bit 0 set asserts the panel reset
    } cmd_op_t;

    typedef logic [7:0] cmd_arg_t;
    typedef logic [9:0] cmd_entry_t;   // {opcode, argument}
    typedef logic [7:0] spi_byte_t;
    typedef logic [4:0] rom_addr_t;

    localparam logic dc_cmd  = 1'b0;
    localparam logic dc_data = 1'b1;

    localparam rom_addr_t init_base  = 5'd0;
    localparam rom_addr_t init_len   = 5'd13;
    localparam rom_addr_t frame_base = 5'd13;
    localparam rom_addr_t frame_len  = 5'd11;

    // window covers 320 columns by 240 pages
    localparam cmd_entry_t cmd_table [24] = '{
        {op_reset_pin, 8'h01},  // hold panel in reset
        {op_delay,     8'h0A},  // 10 ms
        {op_reset_pin, 8'h00},  // release reset
        {op_delay,     8'h78},  // 120 ms
        {op_reg_addr,  8'h36},  // memory access control
        {op_dat_byte,  8'hC8},
        {op_reg_addr,  8'h3A},  // pixel format
        {op_dat_byte,  8'h55},  // 16 bit per pixel
        {op_reg_addr,  8'h35},  // tearing line on
        {op_dat_byte,  8'h00},
        {op_reg_addr,  8'h11},  // sleep out
        {op_delay,     8'h78},  // 120 ms
        {op_reg_addr,  8'h29},  // display on
        {op_reg_addr,  8'h2A},  // column address set
        {op_dat_byte,  8'h00},
        {op_dat_byte,  8'h00},
        {op_dat_byte,  8'h01},
        {op_dat_byte,  8'h3F},
        {op_reg_addr,  8'h2B},  // page address set
        {op_dat_byte,  8'h00},
        {op_dat_byte,  8'h00},
        {op_dat_byte,  8'h00},
        {op_dat_byte,  8'hEF},
        {op_reg_addr,  8'h2C}   // memory write, pixels follow
    };

endpackage

`default_nettype wire

// File: rtl/pix_pkg.sv
// RGB565 pixel type, default transparent colour and mixer mode enum
`default_nettype none

package pix_pkg;

    typedef logic [15:0] pixel_t;   // RGB565

    localparam pixel_t default_transparent = 16'hFFFF;

    typedef enum logic [1:0] {
        mix_idle      = 2'd0,
        mix_drain_img = 2'd1,   // discard image beats up to end of frame
        mix_drain_osd = 2'd2,   // discard osd beats up to end of frame
        mix_fill      = 2'd3    // mix pixels into the transmitter
    } mix_mode_t;

endpackage

`default_nettype wire

// File: rtl/lcd_spi_tx.sv
// 9-bit word serializer with a half-rate serial clock
`timescale 1ns/1ps
`default_nettype none

module lcd_spi_tx (
    input  wire                     s_axis_aclk,
    input  wire                     s_axis_aresetn,
    input  wire                     cmd_load,
    input  wire                     cmd_dc,
    input  wire lcd_pkg::spi_byte_t cmd_byte,
    input  wire                     pix_load,
    input  wire [15:0]              pix_data,
    output logic                    busy,
    output logic                    lcd_spi_scl,
    output logic                    lcd_spi_sda
);

    logic [17:0] shreg;     // msb on the line
    logic [4:0]  bit_cnt;   // bits left after the current one
    logic        phase;     // 0 scl low, 1 scl high

    always_ff @(posedge s_axis_aclk) begin
        if (!s_axis_aresetn) begin
            busy    <= 1'b0;
            phase   <= 1'b0;
            bit_cnt <= '0;
        end else if (cmd_load || pix_load) begin
            busy    <= 1'b1;
            phase   <= 1'b0;
            bit_cnt <= cmd_load ? 5'd8 : 5'd17;
        end else if (busy) begin
            phase <= ~phase;
            if (phase) begin
                if (bit_cnt == 5'd0) begin
                    busy <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge s_axis_aclk) begin
        if (cmd_load) begin
            shreg <= {cmd_dc, cmd_byte, 9'h000};
        end else if (pix_load) begin
            shreg <= {lcd_pkg::dc_data, pix_data[15:8], lcd_pkg::dc_data, pix_data[7:0]};
        end else if (busy && phase) begin
            shreg <= {shreg[16:0], 1'b0};   // advance after the high phase
        end
    end

    assign lcd_spi_scl = busy & phase;
    assign lcd_spi_sda = shreg[17];

    load_when_idle: assert property (@(posedge s_axis_aclk) disable iff (!s_axis_aresetn)
        (cmd_load || pix_load) |-> !busy);

    // sequencer and mixer share the line and must take turns
    single_loader: assert property (@(posedge s_axis_aclk) disable iff (!s_axis_aresetn)
        !(cmd_load && pix_load));

endmodule

`default_nettype wire

// File: rtl/osd_mixer.sv
// start-of-stream draining, image and osd pixel join, transparent colour select
`timescale 1ns/1ps
`default_nettype none

module osd_mixer #(
    parameter pix_pkg::pixel_t transparent_color = pix_pkg::default_transparent
) (
    input  wire                     s_axis_aclk,
    input  wire                     s_axis_aresetn,
    input  wire pix_pkg::mix_mode_t mix_mode,
    input  wire                     busy,
    input  wire pix_pkg::pixel_t    s_axis_img_tdata,
    input  wire                     s_axis_img_tvalid,
    output logic                    s_axis_img_tready,
    input  wire                     s_axis_img_tuser,
    input  wire pix_pkg::pixel_t    s_axis_osd_tdata,
    input  wire                     s_axis_osd_tvalid,
    output logic                    s_axis_osd_tready,
    input  wire                     s_axis_osd_tuser,
    output logic                    pix_load,
    output pix_pkg::pixel_t         pix_data,
    output logic                    drain_done,
    output logic                    frame_done
);

    logic fire;
    logic drain_img_rdy;
    logic drain_osd_rdy;
    logic img_beat;
    logic osd_beat;

    // one beat from each stream, only while the line is free
    assign fire = (mix_mode == pix_pkg::mix_fill) && s_axis_img_tvalid && s_axis_osd_tvalid
               && !busy;

    assign s_axis_img_tready = drain_img_rdy | fire;
    assign s_axis_osd_tready = drain_osd_rdy | fire;

    assign img_beat = s_axis_img_tvalid & s_axis_img_tready;
    assign osd_beat = s_axis_osd_tvalid & s_axis_osd_tready;

    assign drain_done = (drain_img_rdy && img_beat && s_axis_img_tuser)
                     || (drain_osd_rdy && osd_beat && s_axis_osd_tuser);

    assign pix_load = fire;
    assign pix_data = (s_axis_osd_tdata == transparent_color) ? s_axis_img_tdata
                                                              : s_axis_osd_tdata;

    always_ff @(posedge s_axis_aclk) begin
        if (!s_axis_aresetn) begin
            drain_img_rdy <= 1'b0;
            drain_osd_rdy <= 1'b0;
            frame_done    <= 1'b0;
        end else begin
            // drop ready on the end-of-frame beat
            drain_img_rdy <= (mix_mode == pix_pkg::mix_drain_img)
                          && !(img_beat && s_axis_img_tuser);
            drain_osd_rdy <= (mix_mode == pix_pkg::mix_drain_osd)
                          && !(osd_beat && s_axis_osd_tuser);
            frame_done    <= fire && s_axis_img_tuser && s_axis_osd_tuser;  // last pixel handed off
        end
    end

endmodule

`default_nettype wire

// File: rtl/lcd_sequencer.sv
// frame state machine, command table walker, millisecond timer and panel reset pin
`timescale 1ns/1ps
`default_nettype none

module lcd_sequencer #(
    parameter int ticks_per_ms = 50000
) (
    input  wire                 s_axis_aclk,
    input  wire                 s_axis_aresetn,
    input  wire                 busy,
    input  wire                 drain_done,
    input  wire                 frame_done,
    output pix_pkg::mix_mode_t  mix_mode,
    output logic                cmd_load,
    output logic                cmd_dc,
    output lcd_pkg::spi_byte_t  cmd_byte,
    output logic                lcd_resetn
);

    localparam int tick_w = $clog2(ticks_per_ms + 1);

    typedef enum logic [2:0] {
        st_reset,
        st_init,
        st_drain_img,
        st_drain_osd,
        st_burst,
        st_fill
    } seq_state_t;

    typedef enum logic [2:0] {
        wk_idle,
        wk_fetch,
        wk_exec,
        wk_wait_tx,
        wk_delay,
        wk_next,
        wk_done
    } walk_state_t;

    seq_state_t          state;
    walk_state_t         walk_state;
    logic                walk_start;
    logic                walk_done;
    logic                send_now;
    lcd_pkg::rom_addr_t  walk_base;
    lcd_pkg::rom_addr_t  walk_len;
    lcd_pkg::rom_addr_t  rom_addr;
    lcd_pkg::rom_addr_t  remaining;
    lcd_pkg::cmd_entry_t entry;
    lcd_pkg::cmd_op_t    entry_op;
    lcd_pkg::cmd_arg_t   entry_arg;
    lcd_pkg::cmd_arg_t   ms_cnt;
    logic [tick_w-1:0]   tick_cnt;
    logic                ms_tick;

    // walker is kicked on entry to init and before every frame
    assign walk_start = (state == st_reset)
                     || (state == st_drain_osd && drain_done)
                     || (state == st_fill && frame_done);
    assign walk_base  = (state == st_reset) ? lcd_pkg::init_base : lcd_pkg::frame_base;
    assign walk_len   = (state == st_reset) ? lcd_pkg::init_len : lcd_pkg::frame_len;
    assign walk_done  = (walk_state == wk_done);

    assign entry_op  = lcd_pkg::cmd_op_t'(entry[9:8]);
    assign entry_arg = entry[7:0];
    assign send_now  = (walk_state == wk_exec) && !busy
                    && (entry_op == lcd_pkg::op_reg_addr || entry_op == lcd_pkg::op_dat_byte);

    always_ff @(posedge s_axis_aclk) begin
        if (!s_axis_aresetn) begin
            state <= st_reset;
        end else begin
            case (state)
                st_reset:     state <= st_init;
                st_init:      if (walk_done) state <= st_drain_img;
                st_drain_img: if (drain_done) state <= st_drain_osd;
                st_drain_osd: if (drain_done) state <= st_burst;
                st_burst:     if (walk_done) state <= st_fill;
                st_fill:      if (frame_done) state <= st_burst;  // next window burst
                default:      state <= st_reset;
            endcase
        end
    end

    always_comb begin
        case (state)
            st_drain_img: mix_mode = pix_pkg::mix_drain_img;
            st_drain_osd: mix_mode = pix_pkg::mix_drain_osd;
            st_fill:      mix_mode = pix_pkg::mix_fill;
            default:      mix_mode = pix_pkg::mix_idle;
        endcase
    end

    // free-running millisecond tick
    always_ff @(posedge s_axis_aclk) begin
        if (!s_axis_aresetn) begin
            tick_cnt <= '0;
            ms_tick  <= 1'b0;
        end else if (tick_cnt == tick_w'(ticks_per_ms - 1)) begin
            tick_cnt <= '0;
            ms_tick  <= 1'b1;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
            ms_tick  <= 1'b0;
        end
    end

    always_ff @(posedge s_axis_aclk) begin
        entry <= lcd_pkg::cmd_table[rom_addr];  // one cycle read latency
    end

    always_ff @(posedge s_axis_aclk) begin
        if (send_now) begin
            cmd_byte <= entry_arg;
            cmd_dc   <= (entry_op == lcd_pkg::op_reg_addr) ? lcd_pkg::dc_cmd : lcd_pkg::dc_data;
        end
    end

    always_ff @(posedge s_axis_aclk) begin
        if (!s_axis_aresetn) begin
            walk_state <= wk_idle;
            rom_addr   <= '0;
            remaining  <= '0;
            ms_cnt     <= '0;
            cmd_load   <= 1'b0;
            lcd_resetn <= 1'b0;
        end else begin
            cmd_load <= send_now;
            case (walk_state)
                wk_idle: begin
                    if (walk_start) begin
                        rom_addr   <= walk_base;
                        remaining  <= walk_len;
                        walk_state <= wk_fetch;
                    end
                end
                wk_fetch: walk_state <= wk_exec;
                wk_exec: begin
                    case (entry_op)
                        lcd_pkg::op_delay: begin
                            ms_cnt     <= '0;
                            walk_state <= wk_delay;
                        end
                        lcd_pkg::op_reset_pin: begin
                            lcd_resetn <= ~entry_arg[0];
                            walk_state <= wk_next;
                        end
                        default: begin
                            if (send_now) walk_state <= wk_wait_tx;
                        end
                    endcase
                end
                wk_wait_tx: begin
                    if (!busy && !cmd_load) walk_state <= wk_next;  // busy lags load by a cycle
                end
                wk_delay: begin
                    if (ms_cnt == entry_arg) begin
                        walk_state <= wk_next;
                    end else if (ms_tick) begin
                        ms_cnt <= ms_cnt + 1'b1;
                    end
                end
                wk_next: begin
                    if (remaining == lcd_pkg::rom_addr_t'(1)) begin
                        walk_state <= wk_done;
                    end else begin
                        rom_addr   <= rom_addr + 1'b1;
                        remaining  <= remaining - 1'b1;
                        walk_state <= wk_fetch;
                    end
                end
                wk_done: walk_state <= wk_idle;
                default: walk_state <= wk_idle;
            endcase
        end
    end

    // a command must never be loaded on top of a pixel still on the line
    cmd_load_idle_tx: assert property (@(posedge s_axis_aclk) disable iff (!s_axis_aresetn)
        $rose(cmd_load) |-> !busy);

endmodule

`default_nettype wire

// File: rtl/lcd_ctrl.sv
// serial TFT controller top level joining sequencer, OSD mixer and serial transmitter
`timescale 1ns/1ps
`default_nettype none

module lcd_ctrl #(
    parameter int              clk_hz            = 50_000_000,
    parameter pix_pkg::pixel_t transparent_color = pix_pkg::default_transparent
) (
    input  wire                  s_axis_aclk,
    input  wire                  s_axis_aresetn,
    input  wire pix_pkg::pixel_t s_axis_img_tdata,
    input  wire                  s_axis_img_tvalid,
    output wire                  s_axis_img_tready,
    input  wire                  s_axis_img_tuser,   // end of frame
    input  wire pix_pkg::pixel_t s_axis_osd_tdata,
    input  wire                  s_axis_osd_tvalid,
    output wire                  s_axis_osd_tready,
    input  wire                  s_axis_osd_tuser,   // end of frame
    output wire                  lcd_spi_scl,
    output wire                  lcd_spi_sda,
    output wire                  lcd_resetn
);

    wire pix_pkg::mix_mode_t mix_mode;
    wire                     drain_done;
    wire                     frame_done;
    wire                     cmd_load;
    wire                     cmd_dc;
    wire lcd_pkg::spi_byte_t cmd_byte;
    wire                     pix_load;
    wire pix_pkg::pixel_t    pix_data;
    wire                     busy;

    lcd_sequencer #(
        .ticks_per_ms (clk_hz / 1000)
    ) u_sequencer (
        .s_axis_aclk    (s_axis_aclk),
        .s_axis_aresetn (s_axis_aresetn),
        .busy           (busy),
        .drain_done     (drain_done),
        .frame_done     (frame_done),
        .mix_mode       (mix_mode),
        .cmd_load       (cmd_load),
        .cmd_dc         (cmd_dc),
        .cmd_byte       (cmd_byte),
        .lcd_resetn     (lcd_resetn)
    );

    osd_mixer #(
        .transparent_color (transparent_color)
    ) u_mixer (
        .s_axis_aclk       (s_axis_aclk),
        .s_axis_aresetn    (s_axis_aresetn),
        .mix_mode          (mix_mode),
        .busy              (busy),
        .s_axis_img_tdata  (s_axis_img_tdata),
        .s_axis_img_tvalid (s_axis_img_tvalid),
        .s_axis_img_tready (s_axis_img_tready),
        .s_axis_img_tuser  (s_axis_img_tuser),
        .s_axis_osd_tdata  (s_axis_osd_tdata),
        .s_axis_osd_tvalid (s_axis_osd_tvalid),
        .s_axis_osd_tready (s_axis_osd_tready),
        .s_axis_osd_tuser  (s_axis_osd_tuser),
        .pix_load          (pix_load),
        .pix_data          (pix_data),
        .drain_done        (drain_done),
        .frame_done        (frame_done)
    );

    lcd_spi_tx u_spi_tx (
        .s_axis_aclk    (s_axis_aclk),
        .s_axis_aresetn (s_axis_aresetn),
        .cmd_load       (cmd_load),
        .cmd_dc         (cmd_dc),
        .cmd_byte       (cmd_byte),
        .pix_load       (pix_load),
        .pix_data       (pix_data),
        .busy           (busy),
        .lcd_spi_scl    (lcd_spi_scl),
        .lcd_spi_sda    (lcd_spi_sda)
    );

endmodule

`default_nettype wire

// File: test/tb_lcd_ctrl.sv
// lcd_ctrl testbench with clock, reset, stream drivers, serial decoder, reference model and checker
`timescale 1ns/1ps
`default_nettype none

module tb_lcd_ctrl;

    localparam int clk_hz       = 10000;
    localparam int ticks_per_ms = clk_hz / 1000;   // 10 cycles per ms
    localparam int frame_pix    = 8;
    localparam int n_frames     = 3;               // first frame pair is drained
    localparam int mixed_frames = n_frames - 1;
    localparam int n_beats      = n_frames * frame_pix;
    localparam pix_pkg::pixel_t transparent = 16'hFFFF;

    logic            s_axis_aclk       = 1'b0;
    logic            s_axis_aresetn    = 1'b0;
    pix_pkg::pixel_t s_axis_img_tdata  = '0;
    logic            s_axis_img_tvalid = 1'b0;
    logic            s_axis_img_tuser  = 1'b0;
    pix_pkg::pixel_t s_axis_osd_tdata  = '0;
    logic            s_axis_osd_tvalid = 1'b0;
    logic            s_axis_osd_tuser  = 1'b0;
    wire             s_axis_img_tready;
    wire             s_axis_osd_tready;
    wire             lcd_spi_scl;
    wire             lcd_spi_sda;
    wire             lcd_resetn;

    pix_pkg::pixel_t img_pix [n_beats];
    pix_pkg::pixel_t osd_pix [n_beats];
    logic [31:0]     gap_rng;
    int              img_idx;
    int              osd_idx;
    logic            scl_prev;
    logic [8:0]      rx_shift;
    int              rx_bits;
    logic [8:0]      rx_words [$];
    int              chk_cnt = 0;

    lcd_ctrl #(
        .clk_hz            (clk_hz),
        .transparent_color (transparent)
    ) u_lcd_ctrl (
        .s_axis_aclk       (s_axis_aclk),
        .s_axis_aresetn    (s_axis_aresetn),
        .s_axis_img_tdata  (s_axis_img_tdata),
        .s_axis_img_tvalid (s_axis_img_tvalid),
        .s_axis_img_tready (s_axis_img_tready),
        .s_axis_img_tuser  (s_axis_img_tuser),
        .s_axis_osd_tdata  (s_axis_osd_tdata),
        .s_axis_osd_tvalid (s_axis_osd_tvalid),
        .s_axis_osd_tready (s_axis_osd_tready),
        .s_axis_osd_tuser  (s_axis_osd_tuser),
        .lcd_spi_scl       (lcd_spi_scl),
        .lcd_spi_sda       (lcd_spi_sda),
        .lcd_resetn        (lcd_resetn)
    );

    always #5 s_axis_aclk = ~s_axis_aclk;   // 100 MHz

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic bit is_sent(input lcd_pkg::cmd_entry_t e);
        lcd_pkg::cmd_op_t op;
        op = lcd_pkg::cmd_op_t'(e[9:8]);
        return (op == lcd_pkg::op_reg_addr) || (op == lcd_pkg::op_dat_byte);
    endfunction

    // register address goes out as a command, everything else as data
    function automatic logic [8:0] entry_word(input lcd_pkg::cmd_entry_t e);
        logic dc;
        dc = (lcd_pkg::cmd_op_t'(e[9:8]) == lcd_pkg::op_reg_addr) ? lcd_pkg::dc_cmd
                                                                  : lcd_pkg::dc_data;
        return {dc, e[7:0]};
    endfunction

    function automatic int count_sent(input int base, input int len);
        int i;
        int n;
        n = 0;
        for (i = base; i < base + len; i++) begin
            if (is_sent(lcd_pkg::cmd_table[i])) n++;
        end
        return n;
    endfunction

    // init words, then burst and pixels per mixed frame, then the burst that follows the last one
    function automatic int ref_total();
        return count_sent(int'(lcd_pkg::init_base), int'(lcd_pkg::init_len))
             + (mixed_frames + 1) * count_sent(int'(lcd_pkg::frame_base), int'(lcd_pkg::frame_len))
             + mixed_frames * frame_pix * 2;
    endfunction

    function automatic logic [8:0] ref_word(input int idx);
        int              n;
        int              i;
        int              f;
        int              p;
        int              b;
        lcd_pkg::cmd_entry_t e;
        pix_pkg::pixel_t px;
        logic [8:0]      w;
        n = 0;
        w = 9'h000;
        for (i = 0; i < int'(lcd_pkg::init_len); i++) begin
            e = lcd_pkg::cmd_table[int'(lcd_pkg::init_base) + i];
            if (is_sent(e)) begin
                if (n == idx) w = entry_word(e);
                n++;
            end
        end
        for (f = 0; f <= mixed_frames; f++) begin
            for (i = 0; i < int'(lcd_pkg::frame_len); i++) begin
                e = lcd_pkg::cmd_table[int'(lcd_pkg::frame_base) + i];
                if (is_sent(e)) begin
                    if (n == idx) w = entry_word(e);
                    n++;
                end
            end
            for (p = 0; f < mixed_frames && p < frame_pix; p++) begin
                b  = (f + 1) * frame_pix + p;
                px = (osd_pix[b] == transparent) ? img_pix[b] : osd_pix[b];
                if (n == idx) w = {1'b1, px[15:8]};   // high byte first
                if (n + 1 == idx) w = {1'b1, px[7:0]};
                n = n + 2;
            end
        end
        return w;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic expect_low(input string name, input logic val);
        assert (val === 1'b0)
        else stop_with_error($sformatf("Fail %s: got 0x%h expected 0x0", name, val));
    endtask

    task automatic fill_pixels();
        logic [31:0] r;
        int          i;
        r = 32'd55;
        for (i = 0; i < n_beats; i++) begin
            r          = xorshift(r);
            img_pix[i] = r[15:0];
            r          = xorshift(r);
            osd_pix[i] = (i % 3 == 0 || r[2:0] == 3'd0) ? transparent : r[31:16];
        end
    endtask

    always @(posedge s_axis_aclk) begin
        if (!s_axis_aresetn) gap_rng <= 32'd55;
        else gap_rng <= xorshift(gap_rng);
    end

    always @(posedge s_axis_aclk) begin
        if (!s_axis_aresetn) begin
            s_axis_img_tvalid <= 1'b0;
            img_idx           <= 0;
        end else if (!s_axis_img_tvalid || s_axis_img_tready) begin
            if (img_idx < n_beats && gap_rng[1:0] != 2'd0) begin   // roughly one gap in four
                s_axis_img_tvalid <= 1'b1;
                s_axis_img_tdata  <= img_pix[img_idx];
                s_axis_img_tuser  <= (img_idx % frame_pix == frame_pix - 1);
                img_idx           <= img_idx + 1;
            end else begin
                s_axis_img_tvalid <= 1'b0;
            end
        end
    end

    always @(posedge s_axis_aclk) begin
        if (!s_axis_aresetn) begin
            s_axis_osd_tvalid <= 1'b0;
            osd_idx           <= 0;
        end else if (!s_axis_osd_tvalid || s_axis_osd_tready) begin
            if (osd_idx < n_beats && gap_rng[3:2] != 2'd0) begin
                s_axis_osd_tvalid <= 1'b1;
                s_axis_osd_tdata  <= osd_pix[osd_idx];
                s_axis_osd_tuser  <= (osd_idx % frame_pix == frame_pix - 1);
                osd_idx           <= osd_idx + 1;
            end else begin
                s_axis_osd_tvalid <= 1'b0;
            end
        end
    end

    // sda sampled where scl has just gone high
    always @(negedge s_axis_aclk) begin
        if (!s_axis_aresetn) begin
            scl_prev <= 1'b0;
            rx_shift <= '0;
            rx_bits  <= 0;
        end else begin
            scl_prev <= lcd_spi_scl;
            if (lcd_spi_scl && !scl_prev) begin
                if (rx_bits == 8) begin
                    rx_words.push_back({rx_shift[7:0], lcd_spi_sda});
                    rx_bits <= 0;
                end else begin
                    rx_shift <= {rx_shift[7:0], lcd_spi_sda};
                    rx_bits  <= rx_bits + 1;
                end
            end
        end
    end

    always @(posedge s_axis_aclk) begin : word_check
        logic [8:0] got;
        logic [8:0] exp;
        if (rx_words.size() != 0) begin
            got = rx_words.pop_front();
            assert (chk_cnt < ref_total())
            else stop_with_error($sformatf("extra serial word 0x%03h after the last burst", got));
            exp = ref_word(chk_cnt);
            assert (got == exp)
            else stop_with_error($sformatf("Fail lcd_spi_sda word %0d: got 0x%03h expected 0x%03h",
                                           chk_cnt, got, exp));
            chk_cnt <= chk_cnt + 1;
        end
    end

    initial begin
        int cnt;
        fill_pixels();
        repeat (2) @(posedge s_axis_aclk);
        s_axis_aresetn <= 1'b1;
        @(negedge s_axis_aclk);
        expect_low("lcd_resetn", lcd_resetn);
        expect_low("s_axis_img_tready", s_axis_img_tready);
        expect_low("s_axis_osd_tready", s_axis_osd_tready);
        expect_low("lcd_spi_scl", lcd_spi_scl);

        cnt = 0;
        while (lcd_resetn !== 1'b1) begin
            @(negedge s_axis_aclk);
            cnt++;
            if (cnt > 20 * ticks_per_ms) stop_with_error("timeout waiting for panel reset release");
        end
        assert (cnt >= 9 * ticks_per_ms)
        else stop_with_error($sformatf("panel reset released after only %0d cycles", cnt));

        cnt = 0;
        while (lcd_spi_scl !== 1'b1) begin
            @(negedge s_axis_aclk);
            cnt++;
            if (cnt > 140 * ticks_per_ms) begin
                stop_with_error("timeout waiting for the first serial word");
            end
        end
        assert (cnt >= 119 * ticks_per_ms)
        else stop_with_error($sformatf("first serial word only %0d cycles after reset release", cnt));

        cnt = 0;
        while (chk_cnt < ref_total()) begin
            @(posedge s_axis_aclk);
            cnt++;
            if (cnt > 50000) stop_with_error("timeout waiting for all expected serial words");
        end

        // late words would trip the checker here
        cnt = 0;
        while (cnt < 100) begin
            @(posedge s_axis_aclk);
            cnt++;
        end
        assert (img_idx == n_beats && osd_idx == n_beats
                && !s_axis_img_tvalid && !s_axis_osd_tvalid)
        else stop_with_error("not every stream beat was taken by the controller");
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
rtl/lcd_pkg.sv
rtl/pix_pkg.sv
rtl/lcd_spi_tx.sv
rtl/osd_mixer.sv
rtl/lcd_sequencer.sv
rtl/lcd_ctrl.sv
test/tb_lcd_ctrl.sv

// File: Makefile
TOP = tb_lcd_ctrl

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test passed" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
